// File: compile.f
vec_pkg.sv
vec_sequencer.sv
vec_decode_table.sv
vec_addr_gen.sv
vector_decoder.sv
tb_vector_decoder.sv

// File: Makefile
# Verilator build and run of the vector decoder testbench

TOP := tb_vector_decoder

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir obj_dir -f compile.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_vector_decoder.sv
/* testbench for the vector decoder: issues core requests, models the load/store
   unit and checks every output cycle by cycle with concurrent assertions */
`timescale 1ns/10ps

module tb_vector_decoder;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_RANDOM = 12;
    localparam int NUM_TESTS  = 10 + NUM_RANDOM;

    logic                            clk = 1'b0;
    logic                            n_reset = 1'b0;
    logic                            apu_req_i = 1'b0;
    logic [vec_pkg::XLEN-1:0]        apu_instr_i = '0;
    logic [vec_pkg::XLEN-1:0]        apu_op1_i = '0;
    logic [vec_pkg::XLEN-1:0]        apu_op2_i = '0;
    logic [vec_pkg::VL_W-1:0]        vl_i = 5'd1;
    logic [vec_pkg::SEW_W-1:0]       vsew_i = '0;
    logic                            vlsu_done_i = 1'b0;
    logic                            apu_gnt_o;
    logic                            apu_rvalid_o;
    logic                            core_halt_o;
    vec_pkg::vlsu_ctrl_t             vlsu_o;
    vec_pkg::pe_ctrl_t               pe_o;
    vec_pkg::vreg_ctrl_t             vreg_o;
    vec_pkg::cfg_ctrl_t              cfg_o;
    logic [vec_pkg::XLEN-1:0]        scalar_op1_o;
    logic [vec_pkg::XLEN-1:0]        scalar_op2_o;
    logic [vec_pkg::IMM_W-1:0]       imm_o;
    logic [vec_pkg::GROUP_W-1:0]     group_o;
    logic [vec_pkg::VREG_ADDR_W-1:0] vs1_addr_o;
    logic [vec_pkg::VREG_ADDR_W-1:0] vs2_addr_o;
    logic [vec_pkg::VREG_ADDR_W-1:0] vd_addr_o;
    logic [vec_pkg::GROUP_W-1:0]     elements_to_write_o;

    // reference model of the running instruction
    logic        exp_exec;
    logic [1:0]  exp_group;
    logic [31:0] exp_instr;
    logic [31:0] exp_op1;
    logic [31:0] exp_op2;
    logic [2:0]  f3;
    logic [5:0]  f6;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        is_cfg;
    logic        is_load;
    logic        is_store;
    logic        is_mem;
    logic        is_arith;
    logic        is_red;
    logic        exp_last;
    logic        exp_end;
    logic [4:0]  step;
    logic [1:0]  exp_etw;
    logic [10:0] exp_imm;
    vec_pkg::pe_ctrl_t   exp_pe;
    vec_pkg::vreg_ctrl_t exp_vreg;
    vec_pkg::cfg_ctrl_t  exp_cfg;
    vec_pkg::vlsu_ctrl_t exp_vlsu;

    int     errors = 0;
    int     tests_done = 0;
    integer seed = 32'h24f1_a8b1;
    integer lsu_seed = 32'h24f1_a8b1;
    logic   lsu_busy = 1'b0;
    int     lsu_delay = 0;

    vec_pkg::vec_funct6_e ops [13] = '{vec_pkg::VADD, vec_pkg::VSUB, vec_pkg::VMIN,
        vec_pkg::VMAX, vec_pkg::VAND, vec_pkg::VOR, vec_pkg::VXOR, vec_pkg::VMV,
        vec_pkg::VSADD, vec_pkg::VSLL, vec_pkg::VSMUL, vec_pkg::VSRL, vec_pkg::VSRA};

    vector_decoder vector_decoder_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    // PE controls of a kept arithmetic instruction
    function automatic vec_pkg::pe_ctrl_t expected_pe(input logic [5:0] f6_in,
                                                      input logic [2:0] f3_in);
        vec_pkg::pe_ctrl_t c;
        c = '0;
        case (f6_in)
            vec_pkg::VSUB, vec_pkg::VMIN, vec_pkg::VMAX: c.op = vec_pkg::PE_SUB;
            vec_pkg::VAND: c.op = vec_pkg::PE_AND;
            vec_pkg::VOR: c.op = vec_pkg::PE_OR;
            vec_pkg::VXOR: c.op = vec_pkg::PE_XOR;
            vec_pkg::VSLL: c.op = (f3_in == vec_pkg::OPMVV) ? vec_pkg::PE_MUL : vec_pkg::PE_LSHIFT;
            vec_pkg::VSMUL: c.op = vec_pkg::PE_MUL;
            vec_pkg::VSRL: c.op = vec_pkg::PE_RSHIFT_LOG;
            vec_pkg::VSRA: c.op = vec_pkg::PE_RSHIFT_AR;
            default: c.op = vec_pkg::PE_ADD;
        endcase
        if (f3_in == vec_pkg::OPMVV && (f6_in == vec_pkg::VADD || f6_in == vec_pkg::VMAX))
            c.operand = vec_pkg::OPND_RIPPLE;
        else if (f3_in == vec_pkg::OPIVX)
            c.operand = vec_pkg::OPND_SCALAR;
        else if (f3_in == vec_pkg::OPIVI)
            c.operand = vec_pkg::OPND_IMMEDIATE;
        if (f6_in == vec_pkg::VSADD)
            c.sat = vec_pkg::SAT_ON;
        else if (f6_in == vec_pkg::VSMUL)
            c.sat = vec_pkg::SAT_UPPER;
        if (f6_in == vec_pkg::VMIN)
            c.out_mode = vec_pkg::OUT_PASS_MIN;
        else if (f6_in == vec_pkg::VMAX)
            c.out_mode = vec_pkg::OUT_PASS_MAX;
        c.unsigned_imm = (f6_in == vec_pkg::VSRL || f6_in == vec_pkg::VSRA)
                         && f3_in == vec_pkg::OPIVI;
        return c;
    endfunction

    // operand category among the forms each operation really has
    function automatic logic [2:0] pick_funct3(input logic [5:0] f6_in, input logic [3:0] r);
        logic [2:0] sel;
        sel = vec_pkg::OPIVV;
        case (f6_in)
            vec_pkg::VMV: sel = r[0] ? vec_pkg::OPIVI : vec_pkg::OPIVX;
            vec_pkg::VSLL, vec_pkg::VSRL, vec_pkg::VSRA:
            begin
                if (r[1:0] == 2'd1)
                    sel = vec_pkg::OPIVX;
                else if (r[1:0] == 2'd2)
                    sel = vec_pkg::OPIVI;
                else if (r[1:0] == 2'd3 && f6_in == vec_pkg::VSLL)
                    sel = vec_pkg::OPMVV;
            end
            // OPMVV of these two is the reduction
            vec_pkg::VADD, vec_pkg::VMAX: if (r[0]) sel = r[1] ? vec_pkg::OPMVV : vec_pkg::OPIVX;
            vec_pkg::VMIN, vec_pkg::VSMUL: if (r[0]) sel = vec_pkg::OPIVX;
            default: sel = vec_pkg::OPIVV;
        endcase
        return sel;
    endfunction

    function automatic logic [31:0] op_v(input logic [5:0] f6_in, input logic [2:0] f3_in,
                                         input logic [4:0] vs2, input logic [4:0] vs1,
                                         input logic [4:0] vd);
        return {f6_in, 1'b1, vs2, vs1, f3_in, vd, vec_pkg::OP_V};
    endfunction

    always @(posedge clk or negedge n_reset)
    begin
        if (!n_reset)
        begin
            exp_exec <= 1'b0;
            exp_group <= '0;
            exp_instr <= '0;
            exp_op1 <= '0;
            exp_op2 <= '0;
        end
        else if (!exp_exec)
        begin
            if (apu_req_i)
            begin
                exp_exec <= 1'b1;
                exp_group <= '0;
                exp_instr <= apu_instr_i;
                exp_op1 <= apu_op1_i;
                exp_op2 <= apu_op2_i;
            end
        end
        else if (exp_end)
            exp_exec <= 1'b0;
        else if (!is_mem)
            exp_group <= exp_group + 2'd1;
    end

    always_comb
    begin
        f3 = exp_instr[14:12];
        f6 = exp_instr[31:26];
        rd = exp_instr[11:7];
        rs1 = exp_instr[19:15];
        rs2 = exp_instr[24:20];
        is_cfg = (exp_instr[6:0] == vec_pkg::OP_V) && (f3 == 3'b111);
        is_load = (exp_instr[6:0] == vec_pkg::LOAD_FP) && (f3 == 3'b111);
        is_store = (exp_instr[6:0] == vec_pkg::STORE_FP) && (f3 == 3'b111);
        is_mem = is_load || is_store;
        is_arith = (exp_instr[6:0] == vec_pkg::OP_V) && !is_cfg;
        is_red = is_arith && (f3 == vec_pkg::OPMVV)
                 && (f6 == vec_pkg::VADD || f6 == vec_pkg::VMAX);
        // groups of four elements, the last one is (vl - 1) / 4
        exp_last = !is_arith || (int'(exp_group) == (int'(vl_i) - 1) / 4);
        exp_end = is_mem ? vlsu_done_i : exp_last;
        step = (vsew_i == 2'd1) ? {2'b00, exp_group, 1'b0} : {3'b000, exp_group};
        exp_etw = '0;
        if (exp_exec && is_arith && exp_last)
            exp_etw = is_red ? 2'd1 : 2'(vl_i % 4);
        exp_imm = '0;
        if (exp_exec)
            exp_imm = is_cfg ? exp_instr[30:20] : {6'b0, rs1};
        exp_pe = '0;
        exp_vreg = '0;
        exp_cfg = '0;
        exp_vlsu = '0;
        if (exp_exec && is_arith)
        begin
            exp_pe = expected_pe(f6, f3);
            exp_vreg.write = 1'b1;
            if (f6 == vec_pkg::VMV)
                exp_vreg.wb_src = vec_pkg::WB_SCALAR;
        end
        if (exp_exec && is_cfg)
            exp_cfg = '{csr_write: 1'b1, preserve_vl: (rs1 == '0) && (rd == '0),
                        set_vl_max: (rs1 == '0) && (rd != '0)};
        if (exp_exec && is_load)
        begin
            exp_vlsu = '{en: 1'b1, load: 1'b1, store: 1'b0};
            exp_vreg.wb_src = vec_pkg::WB_MEMORY;
        end
        if (exp_exec && is_store)
        begin
            exp_vlsu = '{en: 1'b1, load: 1'b0, store: 1'b1};
            exp_vreg.vs3_src = vec_pkg::VS3_VLSU;
        end
    end

    // load/store unit answers after a random number of cycles
    always @(negedge clk)
    begin
        vlsu_done_i = 1'b0;
        if (vlsu_o.en && !lsu_busy)
        begin
            lsu_busy = 1'b1;
            lsu_delay = $random(lsu_seed) & 7;
        end
        if (lsu_busy)
        begin
            if (lsu_delay == 0)
            begin
                vlsu_done_i = 1'b1;
                lsu_busy = 1'b0;
            end
            else
                lsu_delay = lsu_delay - 1;
        end
    end

    a_handshake: assert property (@(posedge clk) disable iff (!n_reset)
        (apu_gnt_o == !exp_exec) && (core_halt_o == exp_exec)
        && (apu_rvalid_o == (exp_exec && exp_end)))
        else report_error("grant, halt or rvalid differs from the expected state");
    a_pe: assert property (@(posedge clk) disable iff (!n_reset) pe_o == exp_pe)
        else report_error("PE controls wrong");
    a_vreg: assert property (@(posedge clk) disable iff (!n_reset) vreg_o == exp_vreg)
        else report_error("register file controls wrong");
    a_cfg: assert property (@(posedge clk) disable iff (!n_reset) cfg_o == exp_cfg)
        else report_error("CSR controls wrong");
    a_vlsu: assert property (@(posedge clk) disable iff (!n_reset) vlsu_o == exp_vlsu)
        else report_error("load/store controls wrong");
    a_imm: assert property (@(posedge clk) disable iff (!n_reset) imm_o == exp_imm)
        else report_error("immediate wrong");
    a_scalar: assert property (@(posedge clk) disable iff (!n_reset)
        exp_exec |-> (scalar_op1_o == exp_op1) && (scalar_op2_o == exp_op2))
        else report_error("scalar operands differ from the request");
    a_group: assert property (@(posedge clk) disable iff (!n_reset)
        exp_exec |-> (group_o == exp_group))
        else report_error("element group wrong");
    a_addr: assert property (@(posedge clk) disable iff (!n_reset)
        (exp_exec && is_arith) |-> (vs1_addr_o == 5'(rs1 + step))
        && (vs2_addr_o == 5'(rs2 + step)) && (vd_addr_o == (is_red ? rd : 5'(rd + step))))
        else report_error("register address does not follow the element group");
    a_etw: assert property (@(posedge clk) disable iff (!n_reset)
        elements_to_write_o == exp_etw)
        else report_error("elements_to_write wrong");

    task automatic run_instr(input string name, input logic [31:0] instr,
                             input logic [4:0] vl, input logic [1:0] sew);
        int errs_before;
        errs_before = errors;
        @(negedge clk);
        while (!apu_gnt_o)
            @(negedge clk);
        apu_req_i = 1'b1;
        apu_instr_i = instr;
        apu_op1_i = $random(seed);
        apu_op2_i = $random(seed);
        vl_i = vl;
        vsew_i = sew;
        @(negedge clk);
        apu_req_i = 1'b0;
        // halt drops once the instruction has retired
        while (core_halt_o)
            @(negedge clk);
        tests_done++;
        $display("%s: %0d errors", name, errors - errs_before);
    endtask

    initial
    begin
        logic [31:0] r;
        logic [5:0]  op;
        repeat (2) @(negedge clk);
        n_reset = 1'b1;
        repeat (3) @(negedge clk);
        tests_done++;
        $display("reset_idle: %0d errors", errors);
        run_instr("vsetvli_keep_vl", {1'b0, 11'h008, 5'd0, 3'b111, 5'd0, vec_pkg::OP_V}, 5'd4, 2'd0);
        run_instr("vsetvli_vlmax", {1'b0, 11'h008, 5'd0, 3'b111, 5'd5, vec_pkg::OP_V}, 5'd4, 2'd0);
        run_instr("vsetvli_avl", {1'b0, 11'h000, 5'd3, 3'b111, 5'd2, vec_pkg::OP_V}, 5'd4, 2'd0);
        run_instr("vadd_vv_e8", op_v(vec_pkg::VADD, vec_pkg::OPIVV, 5'd8, 5'd4, 5'd16), 5'd9, 2'd0);
        run_instr("vadd_vv_e16", op_v(vec_pkg::VADD, vec_pkg::OPIVV, 5'd8, 5'd4, 5'd16), 5'd9, 2'd1);
        run_instr("vredsum", op_v(vec_pkg::VADD, vec_pkg::OPMVV, 5'd8, 5'd2, 5'd20), 5'd7, 2'd0);
        run_instr("vredmax", op_v(vec_pkg::VMAX, vec_pkg::OPMVV, 5'd6, 5'd1, 5'd3), 5'd13, 2'd1);
        run_instr("vle", {12'h020, 5'd5, 3'b111, 5'd10, vec_pkg::LOAD_FP}, 5'd8, 2'd0);
        run_instr("vse", {12'h020, 5'd6, 3'b111, 5'd12, vec_pkg::STORE_FP}, 5'd8, 2'd0);
        repeat (NUM_RANDOM)
        begin
            r = $random(seed);
            op = ops[{$random(seed)} % 13];
            run_instr("random_arith", op_v(op, pick_funct3(op, r[18:15]), r[4:0], r[9:5],
                      r[14:10]), 5'(({$random(seed)} % 16) + 1), 2'(r[20]));
        end
        repeat (2) @(negedge clk);
        $display("tests run %0d, errors %0d", tests_done, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // each test gets at most 40 clock cycles
    initial
    begin
        #(NUM_TESTS * 40 * CLK_PERIOD);
        $display("watchdog: simulation ran past its time limit");
        $display("test failed");
        $finish;
    end

endmodule

// File: vector_decoder.sv
/* top of the vector decoder: connects the sequencer, decode table and
   address generator to the scalar core, the PE array and the load/store unit */
`timescale 1ns/10ps

module vector_decoder (
    input  logic                               clk,
    input  logic                               n_reset,
    input  logic                               apu_req_i,
    input  logic [vec_pkg::XLEN-1:0]           apu_instr_i,
    input  logic [vec_pkg::XLEN-1:0]           apu_op1_i,
    input  logic [vec_pkg::XLEN-1:0]           apu_op2_i,
    output logic                               apu_gnt_o,
    output logic                               apu_rvalid_o,
    output logic                               core_halt_o,
    input  logic [vec_pkg::VL_W-1:0]           vl_i,
    input  logic [vec_pkg::SEW_W-1:0]          vsew_i,
    input  logic                               vlsu_done_i,
    output vec_pkg::vlsu_ctrl_t                vlsu_o,
    output vec_pkg::pe_ctrl_t                  pe_o,
    output vec_pkg::vreg_ctrl_t                vreg_o,
    output vec_pkg::cfg_ctrl_t                 cfg_o,
    output logic [vec_pkg::XLEN-1:0]           scalar_op1_o,
    output logic [vec_pkg::XLEN-1:0]           scalar_op2_o,
    output logic [vec_pkg::IMM_W-1:0]          imm_o,
    output logic [vec_pkg::GROUP_W-1:0]        group_o,
    output logic [vec_pkg::VREG_ADDR_W-1:0]    vs1_addr_o,
    output logic [vec_pkg::VREG_ADDR_W-1:0]    vs2_addr_o,
    output logic [vec_pkg::VREG_ADDR_W-1:0]    vd_addr_o,
    output logic [vec_pkg::GROUP_W-1:0]        elements_to_write_o
);

    vec_pkg::apu_req_t   req;
    vec_pkg::seq_state_e state;
    logic                last_group;
    logic                multi_cycle;
    logic                fix_vd;
    logic                mem_op;
    logic                ripple;

    assign scalar_op1_o = req.op1;
    assign scalar_op2_o = req.op2;
    assign ripple       = (pe_o.operand == vec_pkg::OPND_RIPPLE);

    vec_sequencer vec_sequencer_i (
        .clk, .n_reset, .apu_req_i, .apu_instr_i, .apu_op1_i, .apu_op2_i, .vl_i, .vlsu_done_i,
        .multi_cycle_i(multi_cycle), .mem_op_i(mem_op), .req_o(req), .state_o(state),
        .group_o, .last_group_o(last_group), .apu_gnt_o, .apu_rvalid_o, .core_halt_o
    );

    vec_decode_table vec_decode_table_i (
        .req_i(req), .state_i(state), .pe_o, .vreg_o, .cfg_o, .vlsu_o,
        .multi_cycle_o(multi_cycle), .fix_vd_o(fix_vd), .mem_op_o(mem_op), .imm_o
    );

    vec_addr_gen vec_addr_gen_i (
        .req_i(req), .group_i(group_o), .last_group_i(last_group), .vsew_i, .vl_i,
        .multi_cycle_i(multi_cycle), .fix_vd_i(fix_vd), .ripple_i(ripple),
        .vs1_addr_o, .vs2_addr_o, .vd_addr_o, .elements_to_write_o
    );

endmodule

// File: vec_addr_gen.sv
/* per-cycle vector register addresses and the number of elements written
   in the current element group */
`timescale 1ns/10ps

module vec_addr_gen (
    input  vec_pkg::apu_req_t                  req_i,
    input  logic [vec_pkg::GROUP_W-1:0]        group_i,
    input  logic                               last_group_i,
    input  logic [vec_pkg::SEW_W-1:0]          vsew_i,
    input  logic [vec_pkg::VL_W-1:0]           vl_i,
    input  logic                               multi_cycle_i,
    input  logic                               fix_vd_i,
    input  logic                               ripple_i,
    output logic [vec_pkg::VREG_ADDR_W-1:0]    vs1_addr_o,
    output logic [vec_pkg::VREG_ADDR_W-1:0]    vs2_addr_o,
    output logic [vec_pkg::VREG_ADDR_W-1:0]    vd_addr_o,
    output logic [vec_pkg::GROUP_W-1:0]        elements_to_write_o
);

    logic [vec_pkg::VREG_ADDR_W-1:0] step;
    logic [vec_pkg::VREG_ADDR_W-1:0] vs1_field;
    logic [vec_pkg::VREG_ADDR_W-1:0] vs2_field;
    logic [vec_pkg::VREG_ADDR_W-1:0] vd_field;

    assign vs1_field = req_i.instr[vec_pkg::VS1_LSB +: vec_pkg::VREG_ADDR_W];
    assign vs2_field = req_i.instr[vec_pkg::VS2_LSB +: vec_pkg::VREG_ADDR_W];
    assign vd_field  = req_i.instr[vec_pkg::VD_LSB +: vec_pkg::VREG_ADDR_W];

    // 16-bit elements fill a group over two registers
    assign step = (vsew_i == vec_pkg::SEW_16) ? (vec_pkg::VREG_ADDR_W'(group_i) << 1)
                                              : vec_pkg::VREG_ADDR_W'(group_i);

    assign vs1_addr_o = vs1_field + step;
    assign vs2_addr_o = vs2_field + step;
    assign vd_addr_o  = fix_vd_i ? vd_field : vd_field + step;

    always_comb
    begin
        elements_to_write_o = '0;
        if (multi_cycle_i && last_group_i)
        begin
            // a reduction leaves its result in a single element
            if (ripple_i)
                elements_to_write_o = vec_pkg::GROUP_W'(1);
            else
                elements_to_write_o = vec_pkg::GROUP_W'(vl_i % vec_pkg::LANES);
        end
    end

endmodule

// File: vec_decode_table.sv
/* combinational decode of the captured instruction into PE, register file,
   CSR and load/store controls; everything idles outside EXEC */
`timescale 1ns/10ps

module vec_decode_table (
    input  vec_pkg::apu_req_t              req_i,
    input  vec_pkg::seq_state_e            state_i,
    output vec_pkg::pe_ctrl_t              pe_o,
    output vec_pkg::vreg_ctrl_t            vreg_o,
    output vec_pkg::cfg_ctrl_t             cfg_o,
    output vec_pkg::vlsu_ctrl_t            vlsu_o,
    output logic                           multi_cycle_o,
    output logic                           fix_vd_o,
    output logic                           mem_op_o,
    output logic [vec_pkg::IMM_W-1:0]      imm_o
);

    logic [vec_pkg::OPCODE_W-1:0]    opcode;
    logic [vec_pkg::FUNCT3_W-1:0]    funct3;
    logic [vec_pkg::FUNCT6_W-1:0]    funct6;
    logic [vec_pkg::VREG_ADDR_W-1:0] vs1_field;
    logic [vec_pkg::VREG_ADDR_W-1:0] vd_field;
    logic                            vec_arith;

    // vv takes vs1, vx the scalar, vi the immediate where the op has a vi form
    function automatic vec_pkg::pe_operand_e operand_of(input logic [2:0] f3, input logic imm_ok);
        vec_pkg::pe_operand_e sel;
        sel = vec_pkg::OPND_VS1;
        if (f3 == vec_pkg::OPIVX)
            sel = vec_pkg::OPND_SCALAR;
        else if (f3 == vec_pkg::OPIVI && imm_ok)
            sel = vec_pkg::OPND_IMMEDIATE;
        return sel;
    endfunction

    assign opcode    = req_i.instr[vec_pkg::OPCODE_LSB +: vec_pkg::OPCODE_W];
    assign funct3    = req_i.instr[vec_pkg::FUNCT3_LSB +: vec_pkg::FUNCT3_W];
    assign funct6    = req_i.instr[vec_pkg::FUNCT6_LSB +: vec_pkg::FUNCT6_W];
    assign vs1_field = req_i.instr[vec_pkg::VS1_LSB +: vec_pkg::VREG_ADDR_W];
    assign vd_field  = req_i.instr[vec_pkg::VD_LSB +: vec_pkg::VREG_ADDR_W];

    always_comb
    begin
        pe_o = '{op: vec_pkg::PE_ADD, operand: vec_pkg::OPND_VS1, sat: vec_pkg::SAT_NONE,
                 out_mode: vec_pkg::OUT_RESULT, unsigned_imm: 1'b0};
        vreg_o = '{write: 1'b0, wb_src: vec_pkg::WB_ARITH, vs3_src: vec_pkg::VS3_DECODE};
        cfg_o = '0;
        vlsu_o = '0;
        fix_vd_o = 1'b0;
        imm_o = '0;
        vec_arith = 1'b0;

        if (state_i == vec_pkg::EXEC)
        begin
            if (opcode == vec_pkg::OP_V && funct3 == vec_pkg::OPCFG)
                imm_o = req_i.instr[vec_pkg::CFG_IMM_LSB +: vec_pkg::IMM_W];
            else
                imm_o = vec_pkg::IMM_W'(vs1_field);

            if (opcode == vec_pkg::LOAD_FP && funct3 == vec_pkg::MEM_WIDTH)
            begin
                vreg_o.wb_src = vec_pkg::WB_MEMORY;
                vlsu_o = '{en: 1'b1, load: 1'b1, store: 1'b0};
            end
            else if (opcode == vec_pkg::STORE_FP && funct3 == vec_pkg::MEM_WIDTH)
            begin
                vreg_o.vs3_src = vec_pkg::VS3_VLSU;
                fix_vd_o = 1'b1;
                vlsu_o = '{en: 1'b1, load: 1'b0, store: 1'b1};
            end
            else if (opcode == vec_pkg::OP_V && funct3 == vec_pkg::OPCFG)
            begin
                // rs1 = x0 keeps vl when rd = x0, otherwise requests vlmax
                cfg_o.csr_write = 1'b1;
                cfg_o.preserve_vl = (vs1_field == '0) && (vd_field == '0);
                cfg_o.set_vl_max = (vs1_field == '0) && (vd_field != '0);
            end
            else if (opcode == vec_pkg::OP_V)
            begin
                vec_arith = 1'b1;
                case (funct6)
                    vec_pkg::VADD:
                    begin
                        pe_o.operand = operand_of(funct3, 1'b0);
                        // vredsum accumulates across groups into a fixed vd
                        if (funct3 == vec_pkg::OPMVV)
                        begin
                            pe_o.operand = vec_pkg::OPND_RIPPLE;
                            fix_vd_o = 1'b1;
                        end
                    end
                    vec_pkg::VSUB: pe_o.op = vec_pkg::PE_SUB;
                    vec_pkg::VMIN:
                    begin
                        pe_o.op = vec_pkg::PE_SUB;
                        pe_o.out_mode = vec_pkg::OUT_PASS_MIN;
                        pe_o.operand = operand_of(funct3, 1'b0);
                    end
                    vec_pkg::VMAX:
                    begin
                        pe_o.op = vec_pkg::PE_SUB;
                        pe_o.out_mode = vec_pkg::OUT_PASS_MAX;
                        pe_o.operand = operand_of(funct3, 1'b0);
                        if (funct3 == vec_pkg::OPMVV)
                        begin
                            pe_o.operand = vec_pkg::OPND_RIPPLE;
                            fix_vd_o = 1'b1;
                        end
                    end
                    vec_pkg::VAND: pe_o.op = vec_pkg::PE_AND;
                    vec_pkg::VOR: pe_o.op = vec_pkg::PE_OR;
                    vec_pkg::VXOR: pe_o.op = vec_pkg::PE_XOR;
                    vec_pkg::VMV:
                    begin
                        vreg_o.wb_src = vec_pkg::WB_SCALAR;
                        pe_o.operand = operand_of(funct3, 1'b1);
                    end
                    vec_pkg::VSADD:
                    begin
                        pe_o.sat = vec_pkg::SAT_ON;
                    end
                    vec_pkg::VSLL:
                    begin
                        // OPMVV form of this code is vmul
                        pe_o.op = (funct3 == vec_pkg::OPMVV) ? vec_pkg::PE_MUL : vec_pkg::PE_LSHIFT;
                        pe_o.operand = operand_of(funct3, 1'b1);
                    end
                    vec_pkg::VSMUL:
                    begin
                        pe_o.op = vec_pkg::PE_MUL;
                        pe_o.sat = vec_pkg::SAT_UPPER;
                        pe_o.operand = operand_of(funct3, 1'b0);
                    end
                    vec_pkg::VSRL, vec_pkg::VSRA:
                    begin
                        pe_o.op = (funct6 == vec_pkg::VSRA) ? vec_pkg::PE_RSHIFT_AR
                                                             : vec_pkg::PE_RSHIFT_LOG;
                        pe_o.operand = operand_of(funct3, 1'b1);
                        pe_o.unsigned_imm = (funct3 == vec_pkg::OPIVI);
                    end
                    default: vec_arith = 1'b0;
                endcase
            end
        end

        vreg_o.write = vreg_o.write | vec_arith;
        multi_cycle_o = vec_arith;
        mem_op_o = vlsu_o.en;
    end

endmodule

// File: vec_sequencer.sv
/* request capture, WAIT/EXEC state machine and element-group counter;
   drives the core handshake (grant, result valid, halt) */
`timescale 1ns/10ps

module vec_sequencer (
    input  logic                               clk,
    input  logic                               n_reset,
    input  logic                               apu_req_i,
    input  logic [vec_pkg::XLEN-1:0]           apu_instr_i,
    input  logic [vec_pkg::XLEN-1:0]           apu_op1_i,
    input  logic [vec_pkg::XLEN-1:0]           apu_op2_i,
    input  logic [vec_pkg::VL_W-1:0]           vl_i,
    input  logic                               vlsu_done_i,
    input  logic                               multi_cycle_i,
    input  logic                               mem_op_i,
    output vec_pkg::apu_req_t                  req_o,
    output vec_pkg::seq_state_e                state_o,
    output logic [vec_pkg::GROUP_W-1:0]        group_o,
    output logic                               last_group_o,
    output logic                               apu_gnt_o,
    output logic                               apu_rvalid_o,
    output logic                               core_halt_o
);

    vec_pkg::seq_state_e         state_q;
    vec_pkg::seq_state_e         state_d;
    vec_pkg::apu_req_t           req_q;
    logic [vec_pkg::GROUP_W-1:0] group_q;
    logic [vec_pkg::GROUP_W-1:0] final_group;
    logic [vec_pkg::VL_W-1:0]    vl_m1;
    logic                        done;

    // one group of LANES elements per cycle, single cycle when not stepping
    assign vl_m1       = vl_i - 1'b1;
    assign final_group = multi_cycle_i ? vl_m1[vec_pkg::LANE_SHIFT +: vec_pkg::GROUP_W] : '0;
    assign last_group_o = (group_q == final_group);
    assign done        = mem_op_i ? vlsu_done_i : last_group_o;

    always_ff @(posedge clk)
    begin
        if (state_q == vec_pkg::WAIT && apu_req_i)
            req_q <= '{instr: apu_instr_i, op1: apu_op1_i, op2: apu_op2_i};
    end

    always_ff @(posedge clk, negedge n_reset)
    begin
        if (!n_reset)
        begin
            state_q <= vec_pkg::WAIT;
            group_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            // memory instructions keep the counter at 0
            if (state_q == vec_pkg::EXEC && !done && !mem_op_i)
                group_q <= group_q + 1'b1;
            else
                group_q <= '0;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            vec_pkg::WAIT: if (apu_req_i) state_d = vec_pkg::EXEC;
            vec_pkg::EXEC: if (done) state_d = vec_pkg::WAIT;
            default: state_d = vec_pkg::WAIT;
        endcase
    end

    assign apu_gnt_o    = (state_q == vec_pkg::WAIT);
    assign core_halt_o  = (state_q == vec_pkg::EXEC);
    assign apu_rvalid_o = (state_q == vec_pkg::EXEC) && done;
    assign req_o        = req_q;
    assign state_o      = state_q;
    assign group_o      = group_q;

    a_group_bound: assert property (@(posedge clk) disable iff (!n_reset)
        (state_q == vec_pkg::EXEC) |-> (group_q <= final_group));

endmodule

// File: vec_pkg.sv
/* shared types and constants of the vector decoder: instruction fields,
   opcodes, state and PE enums, and the control structs passed between blocks */
package vec_pkg;

    localparam int XLEN        = 32;
    localparam int VREG_ADDR_W = 5;
    localparam int IMM_W       = 11;
    localparam int VL_W        = 5;
    localparam int GROUP_W     = 2;
    localparam int SEW_W       = 2;
    localparam int LANES       = 4;
    localparam int LANE_SHIFT  = $clog2(LANES);

    // element width code for 16-bit elements
    localparam logic [SEW_W-1:0] SEW_16 = 2'd1;

    // instruction field positions
    localparam int OPCODE_LSB  = 0;
    localparam int OPCODE_W    = 7;
    localparam int VD_LSB      = 7;
    localparam int FUNCT3_LSB  = 12;
    localparam int FUNCT3_W    = 3;
    localparam int VS1_LSB     = 15;
    localparam int VS2_LSB     = 20;
    localparam int CFG_IMM_LSB = 20;
    localparam int FUNCT6_LSB  = 26;
    localparam int FUNCT6_W    = 6;

    typedef enum logic [OPCODE_W-1:0] {
        LOAD_FP  = 7'b0000111,
        STORE_FP = 7'b0100111,
        OP_V     = 7'b1010111
    } vec_opcode_e;

    typedef enum logic [FUNCT3_W-1:0] {
        OPIVV = 3'b000,
        OPMVV = 3'b010,
        OPIVI = 3'b011,
        OPIVX = 3'b100,
        OPMVX = 3'b110,
        OPCFG = 3'b111
    } vec_funct3_e;

    // unit-stride memory accesses share the 111 width encoding with OPCFG
    localparam vec_funct3_e MEM_WIDTH = OPCFG;

    // shared codes: VADD also vredsum, VMAX also vredmax, VSLL also vmul
    typedef enum logic [FUNCT6_W-1:0] {
        VADD  = 6'b000000,
        VSUB  = 6'b000010,
        VMIN  = 6'b000101,
        VMAX  = 6'b000111,
        VAND  = 6'b001001,
        VOR   = 6'b001010,
        VXOR  = 6'b001011,
        VMV   = 6'b010111,
        VSADD = 6'b100001,
        VSLL  = 6'b100101,
        VSMUL = 6'b100111,
        VSRL  = 6'b101000,
        VSRA  = 6'b101001
    } vec_funct6_e;

    typedef enum logic {WAIT, EXEC} seq_state_e;

    typedef enum logic [3:0] {
        PE_ADD, PE_SUB, PE_AND, PE_OR, PE_XOR,
        PE_LSHIFT, PE_RSHIFT_LOG, PE_RSHIFT_AR, PE_MUL
    } pe_arith_op_e;

    typedef enum logic [1:0] {OPND_VS1, OPND_SCALAR, OPND_IMMEDIATE, OPND_RIPPLE} pe_operand_e;
    typedef enum logic [1:0] {SAT_NONE, SAT_ON, SAT_UPPER} pe_sat_e;
    typedef enum logic [1:0] {OUT_RESULT, OUT_PASS_MIN, OUT_PASS_MAX} pe_out_mode_e;
    typedef enum logic [1:0] {WB_ARITH, WB_SCALAR, WB_MEMORY} vreg_wb_src_e;
    typedef enum logic {VS3_DECODE, VS3_VLSU} vs3_src_e;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
    } apu_req_t;

    typedef struct packed {
        pe_arith_op_e op;
        pe_operand_e  operand;
        pe_sat_e      sat;
        pe_out_mode_e out_mode;
        logic         unsigned_imm;
    } pe_ctrl_t;

    typedef struct packed {
        logic         write;
        vreg_wb_src_e wb_src;
        vs3_src_e     vs3_src;
    } vreg_ctrl_t;

    typedef struct packed {
        logic csr_write;
        logic preserve_vl;
        logic set_vl_max;
    } cfg_ctrl_t;

    typedef struct packed {
        logic en;
        logic load;
        logic store;
    } vlsu_ctrl_t;

endpackage
